//--- hw/tawas_params.svh
`ifndef TAWAS_PARAMS_SVH
`define TAWAS_PARAMS_SVH

// registers per slice bank.
`define TAWAS_NREGS 8

`define TAWAS_DW 32
`define TAWAS_PCW 24

// data RAM words.
`define TAWAS_DMEM_DEPTH 64

`endif

//--- hw/tawas_pkg.sv
package tawas_pkg;

  // data RAM is addressed by the low 6 bits of the pointer register.
  // upper pointer bits are ignored.

  typedef enum logic [3:0] {
    OP_NOP  = 4'd0,
    OP_ADD  = 4'd1,
    OP_SUB  = 4'd2,
    OP_AND  = 4'd3,
    OP_OR   = 4'd4,
    OP_XOR  = 4'd5,
    OP_LDI  = 4'd6,
    OP_LD   = 4'd7,
    OP_ST   = 4'd8,
    OP_LDP  = 4'd9,
    OP_CALL = 4'd10,
    OP_RTN  = 4'd11
  } tawas_op_e;

  typedef struct packed {
    tawas_op_e   op;
    logic [2:0]  rd;
    logic [2:0]  ra;
    logic [2:0]  rb;
    logic [2:0]  pad;
    logic [15:0] imm;
  } tawas_instr_t;

endpackage

//--- hw/tawas_rf_if.sv
`timescale 1ns/10ps
`include "tawas_params.svh"

interface au_rf_if import tawas_pkg::*; ();
  localparam int SW = $clog2(`TAWAS_NREGS);

  logic [SW-1:0]        ra_sel;
  logic [SW-1:0]        rb_sel;
  logic [SW-1:0]        dst_sel;
  logic [`TAWAS_DW-1:0] ra;
  logic [`TAWAS_DW-1:0] rb;
  logic                 rd_vld;
  logic [SW-1:0]        rd_sel;
  logic [`TAWAS_DW-1:0] rd;
  tawas_op_e            au_op;
  logic                 au_go;

  modport regfile (input ra_sel, rb_sel, rd_vld, rd_sel, rd, output ra, rb);
  modport ctrl (output ra_sel, rb_sel, dst_sel, au_op, au_go);
  modport au (input ra, rb, dst_sel, au_op, au_go, output rd_vld, rd_sel, rd);
endinterface

interface ls_rf_if import tawas_pkg::*; ();
  localparam int SW = $clog2(`TAWAS_NREGS);

  logic [SW-1:0]        ptr_sel;
  logic [SW-1:0]        store_sel;
  logic [SW-1:0]        dst_sel;
  tawas_op_e            ls_op;
  logic [`TAWAS_DW-1:0] ptr;
  logic [`TAWAS_DW-1:0] store_data;
  logic                 ptr_upd_vld;
  logic [SW-1:0]        ptr_upd_sel;
  logic [`TAWAS_DW-1:0] ptr_upd;
  logic                 load_vld;
  logic [SW-1:0]        load_sel;
  logic [`TAWAS_DW-1:0] load_data;

  modport regfile (input ptr_sel, store_sel, ptr_upd_vld, ptr_upd_sel, ptr_upd,
                   input load_vld, load_sel, load_data, output ptr, store_data);
  modport ctrl (output ptr_sel, store_sel, dst_sel, ls_op);
  modport ls (input ptr_sel, dst_sel, ls_op, ptr, store_data,
              output ptr_upd_vld, ptr_upd_sel, ptr_upd, load_vld, load_sel, load_data);
endinterface

//--- hw/tawas_regfile.sv
`timescale 1ns/10ps
`include "tawas_params.svh"

module tawas_regfile
(
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  slice,
  input  logic                  pc_store,
  input  logic [`TAWAS_PCW-1:0] pc_link,
  input  logic                  e_store,
  input  logic [`TAWAS_DW-1:0]  e,
  output logic [`TAWAS_PCW-1:0] pc_rtn,
  au_rf_if.regfile              au,
  ls_rf_if.regfile              ls
);

  localparam int NREGS = `TAWAS_NREGS;
  localparam int DW = `TAWAS_DW;
  localparam int PCW = `TAWAS_PCW;
  localparam int LINK = NREGS - 1;

  // one bank per slice.
  logic [DW-1:0] bank [2][NREGS];
  logic [DW-1:0] nxt [NREGS];

  // later writes override earlier ones.
  always_comb
  begin
    for (int i = 0; i < NREGS; i++)
    begin
      nxt[i] = bank[slice][i];
    end
    if (pc_store)
    begin
      nxt[LINK] = {{(DW - PCW){1'b0}}, pc_link};
    end
    if (e_store)
    begin
      nxt[0] = e;
    end
    if (au.rd_vld)
    begin
      nxt[au.rd_sel] = au.rd;
    end
    if (ls.ptr_upd_vld)
    begin
      nxt[ls.ptr_upd_sel] = ls.ptr_upd;
    end
    // load data beats the pointer update on ldp with rd == ra.
    if (ls.load_vld)
    begin
      nxt[ls.load_sel] = ls.load_data;
    end
  end

  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      for (int b = 0; b < 2; b++)
      begin
        for (int i = 0; i < NREGS; i++)
        begin
          bank[b][i] <= '0;
        end
      end
    end
    else
    begin
      for (int i = 0; i < NREGS; i++)
      begin
        bank[slice][i] <= nxt[i];
      end
    end
  end

  assign pc_rtn = bank[slice][LINK][PCW-1:0];
  assign au.ra = bank[slice][au.ra_sel];
  assign au.rb = bank[slice][au.rb_sel];
  assign ls.ptr = bank[slice][ls.ptr_sel];
  assign ls.store_data = bank[slice][ls.store_sel];

endmodule

//--- hw/tawas_au.sv
`timescale 1ns/10ps
`include "tawas_params.svh"

module tawas_au import tawas_pkg::*;
(
  au_rf_if.au rf
);

  logic [`TAWAS_DW-1:0] result;

  always_comb
  begin
    case (rf.au_op)
      OP_ADD:
      begin
        result = rf.ra + rf.rb;
      end
      OP_SUB:
      begin
        result = rf.ra - rf.rb;
      end
      OP_AND:
      begin
        result = rf.ra & rf.rb;
      end
      OP_OR:
      begin
        result = rf.ra | rf.rb;
      end
      OP_XOR:
      begin
        result = rf.ra ^ rf.rb;
      end
      default:
      begin
        result = '0;
      end
    endcase
  end

  // write only when ctrl flags an arithmetic op.
  assign rf.rd_vld = rf.au_go;
  assign rf.rd_sel = rf.dst_sel;
  assign rf.rd = result;

endmodule

//--- hw/tawas_ls.sv
`timescale 1ns/10ps
`include "tawas_params.svh"

module tawas_ls import tawas_pkg::*;
(
  input  logic                                  CLK,
  input  logic                                  RST,
  ls_rf_if.ls                                   rf,
  output logic                                  st_vld,
  output logic [$clog2(`TAWAS_DMEM_DEPTH)-1:0]  st_addr,
  output logic [`TAWAS_DW-1:0]                  st_data
);

  localparam int DEPTH = `TAWAS_DMEM_DEPTH;
  localparam int AW = $clog2(DEPTH);

  logic [`TAWAS_DW-1:0] dmem [DEPTH];
  logic [AW-1:0]        addr;
  logic                 is_load;
  logic                 is_store;

  // pointer upper bits are ignored.
  assign addr = rf.ptr[AW-1:0];

  assign is_load = (rf.ls_op == OP_LD) || (rf.ls_op == OP_LDP);
  assign is_store = (rf.ls_op == OP_ST);

  assign rf.load_vld = is_load;
  assign rf.load_sel = rf.dst_sel;
  assign rf.load_data = dmem[addr];

  // post-increment of the pointer on ldp.
  assign rf.ptr_upd_vld = (rf.ls_op == OP_LDP);
  assign rf.ptr_upd_sel = rf.ptr_sel;
  assign rf.ptr_upd = rf.ptr + 1;

  // store monitor, valid ahead of the edge that writes the RAM.
  assign st_vld = is_store;
  assign st_addr = addr;
  assign st_data = rf.store_data;

  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      for (int i = 0; i < DEPTH; i++)
      begin
        dmem[i] <= '0;
      end
    end
    else if (is_store)
    begin
      dmem[addr] <= rf.store_data;
    end
  end

endmodule

//--- hw/tawas_ctrl.sv
`timescale 1ns/10ps
`include "tawas_params.svh"

module tawas_ctrl import tawas_pkg::*;
(
  input  logic                  CLK,
  input  logic                  RST,
  input  logic [31:0]           instr,
  output logic [`TAWAS_PCW-1:0] imem_addr,
  output logic                  imem_slice,
  output logic                  slice,
  output logic                  pc_store,
  output logic [`TAWAS_PCW-1:0] pc_link,
  output logic                  e_store,
  output logic [`TAWAS_DW-1:0]  e,
  input  logic [`TAWAS_PCW-1:0] pc_rtn,
  au_rf_if.ctrl                 au,
  ls_rf_if.ctrl                 ls
);

  localparam int PCW = `TAWAS_PCW;
  localparam int DW = `TAWAS_DW;

  tawas_instr_t   ir;
  logic [PCW-1:0] pc [2];
  logic [PCW-1:0] pc_cur;
  logic [PCW-1:0] pc_nxt;

  assign ir = tawas_instr_t'(instr);

  assign pc_cur = pc[slice];
  assign imem_addr = pc_cur;
  assign imem_slice = slice;

  assign pc_link = pc_cur + 1'b1;
  assign e = DW'(ir.imm);

  assign au.ra_sel = ir.ra;
  assign au.rb_sel = ir.rb;
  assign au.dst_sel = ir.rd;
  assign au.au_op = ir.op;

  assign ls.ptr_sel = ir.ra;
  assign ls.store_sel = ir.rb;
  assign ls.dst_sel = ir.rd;

  always_comb
  begin
    au.au_go = 1'b0;
    ls.ls_op = OP_NOP;
    e_store = 1'b0;
    pc_store = 1'b0;
    pc_nxt = pc_cur + 1'b1;
    case (ir.op)
      OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR:
      begin
        au.au_go = 1'b1;
      end
      OP_LDI:
      begin
        e_store = 1'b1;
      end
      OP_LD, OP_ST, OP_LDP:
      begin
        ls.ls_op = ir.op;
      end
      // link goes to r7 through pc_store.
      OP_CALL:
      begin
        pc_store = 1'b1;
        pc_nxt = PCW'(ir.imm);
      end
      OP_RTN:
      begin
        pc_nxt = pc_rtn;
      end
      default:
      begin
        pc_nxt = pc_cur + 1'b1;
      end
    endcase
  end

  // slices alternate every cycle.
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      slice <= 1'b0;
      pc[0] <= '0;
      pc[1] <= '0;
    end
    else
    begin
      slice <= ~slice;
      pc[slice] <= pc_nxt;
    end
  end

endmodule

//--- hw/tawas_core.sv
`timescale 1ns/10ps
`include "tawas_params.svh"

module tawas_core
(
  input  logic                                 CLK,
  input  logic                                 RST,
  output logic [`TAWAS_PCW-1:0]                imem_addr,
  output logic                                 imem_slice,
  input  logic [31:0]                          instr,
  output logic                                 st_vld,
  output logic [$clog2(`TAWAS_DMEM_DEPTH)-1:0] st_addr,
  output logic [`TAWAS_DW-1:0]                 st_data
);

  logic                  slice;
  logic                  pc_store;
  logic [`TAWAS_PCW-1:0] pc_link;
  logic                  e_store;
  logic [`TAWAS_DW-1:0]  e;
  logic [`TAWAS_PCW-1:0] pc_rtn;

  au_rf_if au_rf ();
  ls_rf_if ls_rf ();

  tawas_ctrl u_ctrl
  (
    .CLK        (CLK),
    .RST        (RST),
    .instr      (instr),
    .imem_addr  (imem_addr),
    .imem_slice (imem_slice),
    .slice      (slice),
    .pc_store   (pc_store),
    .pc_link    (pc_link),
    .e_store    (e_store),
    .e          (e),
    .pc_rtn     (pc_rtn),
    .au         (au_rf.ctrl),
    .ls         (ls_rf.ctrl)
  );

  tawas_regfile u_regfile
  (
    .CLK      (CLK),
    .RST      (RST),
    .slice    (slice),
    .pc_store (pc_store),
    .pc_link  (pc_link),
    .e_store  (e_store),
    .e        (e),
    .pc_rtn   (pc_rtn),
    .au       (au_rf.regfile),
    .ls       (ls_rf.regfile)
  );

  tawas_au u_au
  (
    .rf (au_rf.au)
  );

  tawas_ls u_ls
  (
    .CLK     (CLK),
    .RST     (RST),
    .rf      (ls_rf.ls),
    .st_vld  (st_vld),
    .st_addr (st_addr),
    .st_data (st_data)
  );

endmodule

//--- verif/tawas_tb.sv
`timescale 1ns/10ps
`include "tawas_params.svh"

module tawas_tb import tawas_pkg::*; ();

  localparam int TIMEOUT = 2000;

  logic                  CLK;
  logic                  RST;
  logic [31:0]           instr;
  logic [`TAWAS_PCW-1:0] imem_addr;
  logic                  imem_slice;
  logic                  st_vld;
  logic [5:0]            st_addr;
  logic [31:0]           st_data;

  // program memory, one array per slice.
  logic [31:0] prog [2][256];
  int          wp [2];
  int          halt_pc [2];
  bit          halted [2];

  // reference state.
  logic [31:0] m_regs [2][8];
  logic [23:0] m_pc [2];
  logic [31:0] m_mem [64];
  bit          m_slice;

  bit          exp_vld;
  logic [5:0]  exp_addr;
  logic [31:0] exp_data;
  int          errors;
  int          stores;
  int          cycles;

  tawas_core UUT
  (
    .CLK        (CLK),
    .RST        (RST),
    .imem_addr  (imem_addr),
    .imem_slice (imem_slice),
    .instr      (instr),
    .st_vld     (st_vld),
    .st_addr    (st_addr),
    .st_data    (st_data)
  );

  always #2 CLK = ~CLK;

  function automatic logic [31:0] encode(input tawas_op_e op, input int rd, input int ra,
                                         input int rb, input int imm);
    return {op, rd[2:0], ra[2:0], rb[2:0], 3'b000, imm[15:0]};
  endfunction

  task automatic put(input bit s, input logic [31:0] w);
    prog[s][wp[s]] = w;
    wp[s]++;
  endtask

  // r6 is never written, so or with it copies r0.
  task automatic set_reg(input bit s, input int r, input int val);
    put(s, encode(OP_LDI, 0, 0, 0, val));
    put(s, encode(OP_OR, r, 0, 6, 0));
  endtask

  task automatic put_halt(input bit s);
    halt_pc[s] = wp[s];
    put(s, encode(OP_CALL, 0, 0, 0, wp[s]));
  endtask

  task automatic build_programs();
    tawas_op_e arith [5] = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR};
    for (int i = 0; i < 256; i++)
    begin
      prog[0][i] = '0;
      prog[1][i] = '0;
    end
    wp[0] = 0;
    // r3 is still zero from reset.
    put(0, encode(OP_ST, 0, 1, 3, 0));
    set_reg(0, 1, $urandom % 65536);
    set_reg(0, 2, $urandom % 65536);
    for (int k = 0; k < 5; k++)
    begin
      put(0, encode(arith[k], 3, 3, (k % 2) ? 2 : 1, 0));
      set_reg(0, 5, k + 1);
      put(0, encode(OP_ST, 0, 5, 3, 0));
    end
    for (int j = 0; j < 4; j++)
    begin
      set_reg(0, 4, $urandom % 65536);
      set_reg(0, 5, 8 + ($urandom % 8));
      put(0, encode(OP_ST, 0, 5, 4, 0));
      put(0, encode(OP_LD, 3, 5, 0, 0));
      set_reg(0, 5, 16 + j);
      put(0, encode(OP_ST, 0, 5, 3, 0));
    end
    for (int j = 0; j < 4; j++)
    begin
      set_reg(0, 4, $urandom % 65536);
      set_reg(0, 5, 24 + j);
      put(0, encode(OP_ST, 0, 5, 4, 0));
    end
    // walk the table, summing into r2.
    set_reg(0, 5, 24);
    put(0, encode(OP_XOR, 2, 2, 2, 0));
    for (int j = 0; j < 3; j++)
    begin
      put(0, encode(OP_LDP, 4, 5, 0, 0));
      put(0, encode(OP_ADD, 2, 2, 4, 0));
    end
    set_reg(0, 1, 20);
    put(0, encode(OP_ST, 0, 1, 5, 0));
    set_reg(0, 1, 21);
    put(0, encode(OP_ST, 0, 1, 2, 0));
    set_reg(0, 5, 27);
    put(0, encode(OP_LDP, 5, 5, 0, 0));
    set_reg(0, 1, 22);
    put(0, encode(OP_ST, 0, 1, 5, 0));
    put_halt(0);
    // slice 1 enters its subroutine first, then returns to address 1.
    wp[1] = 0;
    put(1, encode(OP_CALL, 0, 0, 0, 128));
    wp[1] = 128;
    set_reg(1, 1, 32);
    put(1, encode(OP_ST, 0, 1, 7, 0));
    set_reg(1, 1, $urandom % 65536);
    set_reg(1, 2, $urandom % 65536);
    put(1, encode(OP_ADD, 3, 1, 2, 0));
    put(1, encode(OP_XOR, 4, 3, 1, 0));
    for (int j = 0; j < 3; j++)
    begin
      set_reg(1, 5, 33 + j);
      put(1, encode(OP_ST, 0, 5, 2 + j, 0));
    end
    put(1, encode(OP_RTN, 0, 0, 0, 0));
    wp[1] = 1;
    set_reg(1, 2, 40);
    put(1, encode(OP_ST, 0, 2, 1, 0));
    set_reg(1, 2, 41);
    put(1, encode(OP_ST, 0, 2, 7, 0));
    put_halt(1);
  endtask

  // executes one instruction on the reference state, returns 1 for a store.
  function automatic bit model_step(input bit s, input logic [31:0] w,
                                    output logic [5:0] sa, output logic [31:0] sd);
    logic [3:0]  op;
    logic [2:0]  rd;
    logic [2:0]  ra;
    logic [2:0]  rb;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] ld;
    logic [23:0] pc_n;
    bit          st;
    op = w[31:28];
    rd = w[27:25];
    ra = w[24:22];
    rb = w[21:19];
    a = m_regs[s][ra];
    b = m_regs[s][rb];
    ld = m_mem[a[5:0]];
    pc_n = m_pc[s] + 1;
    st = 0;
    sa = a[5:0];
    sd = b;
    case (op)
      OP_ADD: m_regs[s][rd] = a + b;
      OP_SUB: m_regs[s][rd] = a - b;
      OP_AND: m_regs[s][rd] = a & b;
      OP_OR: m_regs[s][rd] = a | b;
      OP_XOR: m_regs[s][rd] = a ^ b;
      OP_LDI: m_regs[s][0] = {16'h0000, w[15:0]};
      OP_LD: m_regs[s][rd] = ld;
      OP_ST:
      begin
        m_mem[a[5:0]] = b;
        st = 1;
      end
      // loaded value lands last, so it wins when rd equals ra.
      OP_LDP:
      begin
        m_regs[s][ra] = a + 1;
        m_regs[s][rd] = ld;
      end
      OP_CALL:
      begin
        m_regs[s][7] = {8'h00, pc_n};
        pc_n = {8'h00, w[15:0]};
      end
      OP_RTN: pc_n = m_regs[s][7][23:0];
      default: pc_n = m_pc[s] + 1;
    endcase
    m_pc[s] = pc_n;
    return st;
  endfunction

  always @(posedge CLK)
  begin
    if (st_vld !== exp_vld)
    begin
      if (exp_vld)
        $display("expected a store to address 0x%0h but none occurred", exp_addr);
      else
        $display("unexpected store to address 0x%0h", st_addr);
      errors++;
    end
    else if (exp_vld)
    begin
      stores++;
      if (st_addr !== exp_addr)
      begin
        $display("MISMATCH st_addr: got 0x%0h, expected 0x%0h", st_addr, exp_addr);
        errors++;
      end
      if (st_data !== exp_data)
      begin
        $display("MISMATCH st_data: got 0x%0h, expected 0x%0h", st_data, exp_data);
        errors++;
      end
    end
  end

  initial
  begin
    CLK = 0;
    RST = 1;
    instr = '0;
    exp_vld = 0;
    errors = 0;
    stores = 0;
    m_slice = 0;
    void'($urandom(14990));
    for (int s = 0; s < 2; s++)
    begin
      m_pc[s] = '0;
      halted[s] = 0;
      for (int r = 0; r < 8; r++)
        m_regs[s][r] = '0;
    end
    for (int i = 0; i < 64; i++)
      m_mem[i] = '0;
    build_programs();
    repeat (3) @(posedge CLK);
    @(negedge CLK);
    RST = 0;
    cycles = 0;
    while (!(halted[0] && halted[1]) && cycles < TIMEOUT)
    begin
      if (imem_slice !== m_slice)
      begin
        $display("MISMATCH imem_slice: got 0x%0h, expected 0x%0h", imem_slice, m_slice);
        errors++;
      end
      if (imem_addr !== m_pc[m_slice])
      begin
        $display("MISMATCH imem_addr: got 0x%0h, expected 0x%0h", imem_addr, m_pc[m_slice]);
        errors++;
      end
      if (imem_addr == halt_pc[m_slice])
        halted[m_slice] = 1;
      instr = prog[imem_slice][imem_addr[7:0]];
      exp_vld = model_step(m_slice, instr, exp_addr, exp_data);
      m_slice = ~m_slice;
      cycles++;
      @(negedge CLK);
    end
    if (!(halted[0] && halted[1]))
    begin
      $display("timeout: both slices did not reach their halt address in %0d cycles", TIMEOUT);
      errors++;
    end
    $display("errors: %0d, stores checked: %0d", errors, stores);
    if (errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

//--- filelist.f
+incdir+hw
hw/tawas_pkg.sv
hw/tawas_rf_if.sv
hw/tawas_regfile.sv
hw/tawas_au.sv
hw/tawas_ls.sv
hw/tawas_ctrl.sv
hw/tawas_core.sv
verif/tawas_tb.sv
